// ==== zx_periph_pkg.sv ====
// shared definitions for the spi input subsystem
// spi command codes, record sizes, z80 port bytes and reset values

package zx_periph_pkg;

	// default depth of the spi pin synchronizer
	localparam int SYNC_STAGES_DEF = 2;

	// command byte, first byte of every spi frame
	typedef enum logic [7:0]
	{
		CMD_KBD    = 8'h10, // keyboard record, five bytes follow
		CMD_MUSX   = 8'h20,
		CMD_MUSY   = 8'h21,
		CMD_MUSBTN = 8'h22,
		CMD_KJ     = 8'h23  // kempston joystick, low five bits used
	} cmd_t;

	localparam int KBD_BYTES = 5;
	localparam int KBD_BITS  = 40; // 8 half-rows of 5 keys

	// low address bytes of the z80 ports
	localparam logic [7:0] PORT_KBD_LO = 8'hFE; // only bit 0 decoded
	localparam logic [7:0] PORT_KJ_LO  = 8'h1F;
	localparam logic [7:0] PORT_MUS_LO = 8'hDF;

	// register contents after reset
	localparam logic [7:0] MUS_RST = 8'hFF;
	localparam logic [4:0] KJ_RST  = 5'b00000;

	// key vector of all zeros means no key pressed
	localparam logic [KBD_BITS-1:0] KBD_RST = '0;

endpackage

// ==== periph_load_if.sv ====
// load path from the spi command controller to the register block
// payloads plus one strobe per destination register

interface periph_load_if
	import zx_periph_pkg::*;
();

	logic [7:0]          byte_data; // mouse and joystick payload
	logic [KBD_BITS-1:0] kbd_word;  // complete key vector

	// one cycle pulses, only while f0 is high
	logic kbd_stb;
	logic musx_stb;
	logic musy_stb;
	logic musbtn_stb;
	logic kj_stb;

	modport ctrl
	(
		output byte_data, kbd_word,
		output kbd_stb, musx_stb, musy_stb, musbtn_stb, kj_stb
	);

	modport regs
	(
		input byte_data, kbd_word,
		input kbd_stb, musx_stb, musy_stb, musbtn_stb, kj_stb
	);

endinterface

// ==== slave_spi_rx.sv ====
// spi slave receiver, mode 0, msb first
// pin synchronizers, sck and cs_n edge detect, byte assembly

module slave_spi_rx
#(
	parameter int SYNC_STAGES = 2
)
(
	input  logic       fclk,
	input  logic       rst_n,
	input  logic       spi_sck,
	input  logic       spi_mosi,
	input  logic       spi_cs_n,
	output logic [7:0] rx_byte,
	output logic       rx_stb,
	output logic       frame_start,
	output logic       frame_end
);

	logic [SYNC_STAGES-1:0] sck_sync, mosi_sync, cs_sync;

	logic sck_s, mosi_s, cs_s;
	logic sck_d, cs_d;     // one cycle later, for edges
	logic sck_rise, cs_fall, cs_rise;
	logic bit_in;          // sampling edge inside a frame
	logic byte_done;

	logic [2:0] bit_cnt;
	logic [7:0] shreg;

	assign sck_s  = sck_sync[SYNC_STAGES-1];
	assign mosi_s = mosi_sync[SYNC_STAGES-1];
	assign cs_s   = cs_sync[SYNC_STAGES-1];

	assign sck_rise = sck_s & ~sck_d;
	assign cs_fall  = ~cs_s & cs_d;
	assign cs_rise  = cs_s & ~cs_d;

	assign bit_in    = sck_rise & ~cs_s & ~cs_fall;
	assign byte_done = bit_in & (bit_cnt == 3'd7);

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sck_sync    <= '0;
			mosi_sync   <= '0;
			cs_sync     <= '1; // idle: deselected
			sck_d       <= 1'b0;
			cs_d        <= 1'b1;
			bit_cnt     <= 3'd0;
			rx_stb      <= 1'b0;
			frame_start <= 1'b0;
			frame_end   <= 1'b0;
		end
		else
		begin
			sck_sync  <= {sck_sync[SYNC_STAGES-2:0], spi_sck};
			mosi_sync <= {mosi_sync[SYNC_STAGES-2:0], spi_mosi};
			cs_sync   <= {cs_sync[SYNC_STAGES-2:0], spi_cs_n};
			sck_d     <= sck_s;
			cs_d      <= cs_s;

			frame_start <= cs_fall;
			frame_end   <= cs_rise;
			rx_stb      <= byte_done;

			if (cs_fall)
				bit_cnt <= 3'd0;
			else if (bit_in)
				bit_cnt <= bit_cnt + 3'd1; // wraps after eight bits
		end
	end

	// shifter and output byte
	always_ff @(posedge fclk)
	begin
		if (bit_in)
			shreg <= {shreg[6:0], mosi_s};
		if (byte_done)
			rx_byte <= {shreg[6:0], mosi_s};
	end

endmodule

// ==== spi_cmd_ctrl.sv ====
// spi frame interpreter: command byte then payload
// keyboard record staging and f0 aligned load strobes

module spi_cmd_ctrl
	import zx_periph_pkg::*;
(
	input  logic       fclk,
	input  logic       rst_n,
	input  logic       f0,
	input  logic [7:0] rx_byte,
	input  logic       rx_stb,
	input  logic       frame_start,
	input  logic       frame_end,
	periph_load_if.ctrl ld
);

	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_CMD,
		ST_PAYLOAD,
		ST_DISCARD
	} state_t;

	localparam int IDX_W = $clog2(KBD_BYTES);
	localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(KBD_BYTES - 1);

	state_t state;
	cmd_t   cmd;
	cmd_t   pend_cmd;   // destination of the pending byte
	logic   pend_kbd;
	logic   pend_byte;

	logic [IDX_W-1:0]    idx; // keyboard byte number
	logic [KBD_BITS-1:0] stage;
	logic [KBD_BITS-1:0] kbd_q;
	logic [7:0]          byte_q;

	logic known_cmd;
	logic payload_stb;
	logic kbd_last;

	assign known_cmd = rx_byte inside {CMD_KBD, CMD_MUSX, CMD_MUSY, CMD_MUSBTN, CMD_KJ};

	// a frame edge in the same cycle wins over the byte
	assign payload_stb = rx_stb & (state == ST_PAYLOAD) & ~frame_start & ~frame_end;
	assign kbd_last    = (idx == IDX_LAST);

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= ST_IDLE;
			cmd       <= CMD_KBD;
			pend_cmd  <= CMD_KBD;
			idx       <= '0;
			pend_kbd  <= 1'b0;
			pend_byte <= 1'b0;
		end
		else
		begin
			if (f0)
			begin
				pend_kbd  <= 1'b0; // strobe went out this cycle
				pend_byte <= 1'b0;
			end

			if (frame_start)
				state <= ST_CMD; // partial record dropped
			else if (frame_end)
				state <= ST_IDLE;
			else if (rx_stb)
			begin
				case (state)
					ST_CMD:
					begin
						cmd   <= cmd_t'(rx_byte);
						idx   <= '0;
						state <= known_cmd ? ST_PAYLOAD : ST_DISCARD;
					end
					ST_PAYLOAD:
					begin
						if (cmd == CMD_KBD)
						begin
							idx <= idx + 1'b1;
							if (kbd_last)
							begin
								pend_kbd <= 1'b1;
								state    <= ST_DISCARD;
							end
						end
						else
						begin
							pend_byte <= 1'b1;
							pend_cmd  <= cmd;
							state     <= ST_DISCARD;
						end
					end
					default: ; // idle and discard ignore bytes
				endcase
			end
		end
	end

	// payload registers, kbd_q changes only on a full record
	always_ff @(posedge fclk)
	begin
		if (payload_stb)
		begin
			if (cmd == CMD_KBD)
			begin
				stage[idx*8 +: 8] <= rx_byte;
				if (kbd_last)
					kbd_q <= {rx_byte, stage[KBD_BITS-9:0]};
			end
			else
				byte_q <= rx_byte;
		end
	end

	assign ld.kbd_word   = kbd_q;
	assign ld.byte_data  = byte_q;
	assign ld.kbd_stb    = f0 & pend_kbd;
	assign ld.musx_stb   = f0 & pend_byte & (pend_cmd == CMD_MUSX);
	assign ld.musy_stb   = f0 & pend_byte & (pend_cmd == CMD_MUSY);
	assign ld.musbtn_stb = f0 & pend_byte & (pend_cmd == CMD_MUSBTN);
	assign ld.kj_stb     = f0 & pend_byte & (pend_cmd == CMD_KJ);

endmodule

// ==== kbd_mus_regs.sv ====
// key matrix, mouse and joystick registers
// half-row key data and mouse byte selected by the high address byte

module kbd_mus_regs
	import zx_periph_pkg::*;
(
	input  logic       fclk,
	input  logic       rst_n,
	periph_load_if.regs ld,
	input  logic [7:0] zah,
	output logic [4:0] kbd_data,
	output logic [7:0] mus_data,
	output logic [4:0] kj_data
);

	logic [KBD_BITS-1:0] kbd;
	logic [7:0] musx, musy, musbtn;
	logic [4:0] kj;

	logic [4:0] keys [8]; // one entry per half-row
	logic [4:0] kout;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			kbd    <= KBD_RST;
			musx   <= MUS_RST;
			musy   <= MUS_RST;
			musbtn <= MUS_RST;
			kj     <= KJ_RST;
		end
		else
		begin
			if (ld.kbd_stb)
				kbd <= ld.kbd_word;
			if (ld.musx_stb)
				musx <= ld.byte_data;
			if (ld.musy_stb)
				musy <= ld.byte_data;
			if (ld.musbtn_stb)
				musbtn <= ld.byte_data;
			if (ld.kj_stb)
				kj <= ld.byte_data[4:0]; // fire and directions only
		end
	end

	// half-row r: bits r, r+8 .. r+32, bit r+32 lands in bit 0
	for (genvar r = 0; r < 8; r++)
	begin : g_row
		assign keys[r] = {kbd[r], kbd[r+8], kbd[r+16], kbd[r+24], kbd[r+32]};
	end

	// pressed key pulls its column low on every selected row
	always_comb
	begin
		kout = 5'b11111;
		for (int r = 0; r < 8; r++)
		begin
			if (!zah[r])
				kout = kout & ~keys[r];
		end
	end

	assign kbd_data = kout;

	// FADF buttons, FBDF x, FFDF y
	always_comb
	begin
		if (!zah[0])
			mus_data = musbtn;
		else if (!zah[2])
			mus_data = musx;
		else
			mus_data = musy;
	end

	assign kj_data = kj;

endmodule

// ==== zport_read_mux.sv ====
// z80 port read decode for keyboard, joystick and mouse
// combinational data and output enable

module zport_read_mux
	import zx_periph_pkg::*;
(
	input  logic [15:0] za,
	input  logic        iorq_rd,
	input  logic [4:0]  kbd_data,
	input  logic [7:0]  mus_data,
	input  logic [4:0]  kj_data,
	output logic [7:0]  zdata,
	output logic        zdata_oe
);

	logic [7:0] zal;
	logic       sel_kbd, sel_kj, sel_mus;

	assign zal = za[7:0];

	// #FE answers on any even address
	assign sel_kbd = (zal[0] == PORT_KBD_LO[0]);
	assign sel_kj  = (zal == PORT_KJ_LO);
	assign sel_mus = (zal == PORT_MUS_LO);

	always_comb
	begin
		zdata    = 8'h00;
		zdata_oe = 1'b0;

		if (iorq_rd)
		begin
			if (sel_kbd)
			begin
				// no tape input, bit 6 stays high
				zdata    = {3'b111, kbd_data};
				zdata_oe = 1'b1;
			end
			else if (sel_kj)
			begin
				zdata    = {3'b000, kj_data};
				zdata_oe = 1'b1;
			end
			else if (sel_mus)
			begin
				zdata    = mus_data;
				zdata_oe = 1'b1;
			end
		end
	end

endmodule

// ==== zkbd_top.sv ====
// input subsystem top: spi receiver, command controller,
// register block and z80 read mux

module zkbd_top
	import zx_periph_pkg::*;
#(
	parameter int SYNC_STAGES = SYNC_STAGES_DEF
)
(
	input  logic        fclk,
	input  logic        rst_n,
	input  logic        f0,
	input  logic        spi_sck,
	input  logic        spi_mosi,
	input  logic        spi_cs_n,
	input  logic [15:0] za,
	input  logic        iorq_rd,
	output logic [7:0]  zdata,
	output logic        zdata_oe
);

	logic [7:0] rx_byte;
	logic       rx_stb, frame_start, frame_end;
	logic [4:0] kbd_data, kj_data;
	logic [7:0] mus_data;

	periph_load_if ld ();

	slave_spi_rx #(
		.SYNC_STAGES(SYNC_STAGES)
	) slave_spi_rx_i (
		.fclk(fclk), .rst_n(rst_n),
		.spi_sck(spi_sck), .spi_mosi(spi_mosi), .spi_cs_n(spi_cs_n),
		.rx_byte(rx_byte), .rx_stb(rx_stb),
		.frame_start(frame_start), .frame_end(frame_end)
	);

	spi_cmd_ctrl spi_cmd_ctrl_i (
		.fclk(fclk), .rst_n(rst_n), .f0(f0),
		.rx_byte(rx_byte), .rx_stb(rx_stb),
		.frame_start(frame_start), .frame_end(frame_end),
		.ld(ld.ctrl)
	);

	kbd_mus_regs kbd_mus_regs_i (
		.fclk(fclk), .rst_n(rst_n),
		.ld(ld.regs),
		.zah(za[15:8]), // half-row select and mouse port
		.kbd_data(kbd_data), .mus_data(mus_data), .kj_data(kj_data)
	);

	zport_read_mux zport_read_mux_i (
		.za(za), .iorq_rd(iorq_rd),
		.kbd_data(kbd_data), .mus_data(mus_data), .kj_data(kj_data),
		.zdata(zdata), .zdata_oe(zdata_oe)
	);

endmodule

// ==== tb_clkgen.sv ====
// testbench clock and reset source
// free running fclk, active low reset held for a number of cycles

module tb_clkgen
#(
	parameter int PERIOD_NS  = 40,
	parameter int RST_CYCLES = 16
)
(
	output logic fclk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		fclk = 1'b0;
		forever #(PERIOD_NS / 2) fclk = ~fclk;
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge fclk);
		rst_n <= 1'b1; // released on a rising edge
	end

endmodule

// ==== tb_zkbd.sv ====
// testbench for the spi keyboard, mouse and joystick subsystem
// spi frame driver, lcg stimulus, port model, read assertions, watchdog

module tb_zkbd
	import zx_periph_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int PERIOD_NS    = 40;
	localparam int RST_CYCLES   = 16;
	localparam int SCK_HALF     = 8;  // fclk cycles per sck phase
	localparam int SETTLE       = 20; // load latency bound
	localparam int N_KBD        = 8;
	localparam int N_MUS        = 4;
	localparam int N_KJ         = 4;
	localparam int N_FRAMES     = N_KBD + 3 * N_MUS + N_KJ + 2;
	localparam int FRAME_CYCLES = SCK_HALF * (2 + 16 * (KBD_BYTES + 1)) + SETTLE + 2;
	localparam int READ_CYCLES  = 2000;
	localparam int TIMEOUT_NS   =
		(RST_CYCLES + N_FRAMES * FRAME_CYCLES + READ_CYCLES) * PERIOD_NS;

	logic        fclk, rst_n;
	logic        f0 = 1'b0;
	logic        spi_sck, spi_mosi, spi_cs_n;
	logic [15:0] za;
	logic        iorq_rd;
	logic [7:0]  zdata;
	logic        zdata_oe;

	logic        chk_en;   // a read result is due at the next edge
	logic [7:0]  exp_data;
	logic        exp_oe;
	int          err_count;
	int          n_checks;
	logic [31:0] lcg_state;

	// what the registers should hold
	logic [KBD_BITS-1:0] model_kbd;
	logic [7:0]          model_musx, model_musy, model_musbtn;
	logic [4:0]          model_kj;

	logic [7:0] tx_buf [8]; // bytes of the next spi frame

	tb_clkgen #(
		.PERIOD_NS(PERIOD_NS),
		.RST_CYCLES(RST_CYCLES)
	) clkgen_i (
		.fclk(fclk),
		.rst_n(rst_n)
	);

	zkbd_top #(
		.SYNC_STAGES(2)
	) zkbd_top_i (
		.fclk(fclk), .rst_n(rst_n), .f0(f0),
		.spi_sck(spi_sck), .spi_mosi(spi_mosi), .spi_cs_n(spi_cs_n),
		.za(za), .iorq_rd(iorq_rd),
		.zdata(zdata), .zdata_oe(zdata_oe)
	);

	// clock enable high on every second fclk cycle
	always @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			f0 <= 1'b0;
		else
			f0 <= ~f0;
	end

	task automatic flag_mismatch(input string name, input logic [7:0] expv,
		input logic [7:0] actv);
		err_count++;
		$display("** Error @ %0t ns: %s expected %h, actual %h", $time, name, expv, actv);
	endtask

	data_check: assert property (@(posedge fclk) chk_en |-> (zdata == exp_data))
		else flag_mismatch("zdata", $sampled(exp_data), $sampled(zdata));

	oe_check: assert property (@(posedge fclk) chk_en |-> (zdata_oe == exp_oe))
		else flag_mismatch("zdata_oe", {7'd0, $sampled(exp_oe)},
			{7'd0, $sampled(zdata_oe)});

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [31:0] w;
		w = lcg_next();
		return w[31:24]; // upper bits have the longest period
	endfunction

	// sparse vectors leave some half-rows free
	function automatic logic [KBD_BITS-1:0] rand_keys(input logic sparse);
		logic [KBD_BITS-1:0] v;
		for (int n = 0; n < KBD_BYTES; n++)
			v[8*n +: 8] = sparse ? (rand_byte() & rand_byte()) : rand_byte();
		return v;
	endfunction

	// {oe, data} the z80 should see
	function automatic logic [8:0] expected_read(input logic [15:0] addr, input logic rd);
		logic [7:0] lo, hi;
		logic [4:0] cols;
		lo   = addr[7:0];
		hi   = addr[15:8];
		cols = 5'b11111;
		if (!rd)
			return 9'h000;
		if (!lo[0])
		begin
			// column j of row r is key bit 8*(4-j)+r
			for (int j = 0; j < 5; j++)
				for (int r = 0; r < 8; r++)
					if (!hi[r] && model_kbd[8*(4-j) + r])
						cols[j] = 1'b0;
			return {1'b1, 3'b111, cols};
		end
		if (lo == PORT_KJ_LO)
			return {1'b1, 3'b000, model_kj};
		if (lo == PORT_MUS_LO)
		begin
			if (!hi[0])
				return {1'b1, model_musbtn};
			else if (!hi[2])
				return {1'b1, model_musx};
			else
				return {1'b1, model_musy};
		end
		return 9'h000;
	endfunction

	// one mode 0 byte msb first, entered just after a rising fclk edge
	task automatic shift_byte(input logic [7:0] b);
		for (int i = 7; i >= 0; i--)
		begin
			spi_sck  <= 1'b0;
			spi_mosi <= b[i];
			repeat (SCK_HALF) @(posedge fclk);
			spi_sck <= 1'b1; // slave samples here
			repeat (SCK_HALF) @(posedge fclk);
		end
	endtask

	task automatic send_frame(input int nbytes);
		@(posedge fclk);
		spi_cs_n <= 1'b0;
		repeat (SCK_HALF) @(posedge fclk);
		for (int n = 0; n < nbytes; n++)
			shift_byte(tx_buf[n]);
		spi_sck <= 1'b0;
		repeat (SCK_HALF) @(posedge fclk);
		spi_cs_n <= 1'b1;
		repeat (SETTLE) @(posedge fclk);
	endtask

	task automatic load_kbd(input logic [KBD_BITS-1:0] keys);
		tx_buf[0] = CMD_KBD;
		for (int n = 0; n < KBD_BYTES; n++)
			tx_buf[n+1] = keys[8*n +: 8]; // first byte holds bits 7:0
		send_frame(KBD_BYTES + 1);
		model_kbd = keys;
	endtask

	task automatic load_byte(input cmd_t cmd, input logic [7:0] val);
		tx_buf[0] = cmd;
		tx_buf[1] = val;
		send_frame(2);
		case (cmd)
			CMD_MUSX:   model_musx = val;
			CMD_MUSY:   model_musy = val;
			CMD_MUSBTN: model_musbtn = val;
			CMD_KJ:     model_kj = val[4:0];
			default: ;
		endcase
	endtask

	task automatic read_check(input logic [15:0] addr, input logic rd);
		logic [8:0] e;
		e = expected_read(addr, rd);
		@(posedge fclk);
		za       <= addr;
		iorq_rd  <= rd;
		exp_oe   <= e[8];
		exp_data <= e[7:0];
		chk_en   <= 1'b1;
		n_checks++;
		@(posedge fclk); // assertions sample here
		chk_en  <= 1'b0;
		iorq_rd <= 1'b0;
	endtask

	task automatic sweep_ports();
		read_check(16'h00FE, 1'b1);
		read_check(16'hFFFE, 1'b1);
		read_check({rand_byte(), 8'hFE}, 1'b1);
		read_check({rand_byte(), 8'h7C}, 1'b1); // other even address
		read_check(16'hFADF, 1'b1);
		read_check(16'hFBDF, 1'b1);
		read_check(16'hFFDF, 1'b1);
		read_check({rand_byte(), PORT_KJ_LO}, 1'b1);
	endtask

	initial
	begin
		logic [7:0] lo;
		lcg_state = 32'had40e217;
		err_count = 0;
		n_checks  = 0;
		spi_sck   = 1'b0;
		spi_mosi  = 1'b0;
		spi_cs_n  = 1'b1;
		za        = 16'h0000;
		iorq_rd   = 1'b0;
		chk_en    = 1'b0;
		exp_data  = 8'h00;
		exp_oe    = 1'b0;
		model_kbd    = KBD_RST;
		model_musx   = MUS_RST;
		model_musy   = MUS_RST;
		model_musbtn = MUS_RST;
		model_kj     = KJ_RST;

		@(posedge rst_n);
		repeat (2) @(posedge fclk);
		sweep_ports(); // reset values

		for (int i = 0; i < N_KBD; i++)
		begin
			load_kbd(rand_keys(i % 2 == 1));
			read_check(16'hFFFE, 1'b1);
			read_check(16'h00FE, 1'b1);
			for (int r = 0; r < 8; r++)
				read_check({~(8'd1 << r), 8'hFE}, 1'b1); // single half-row
			for (int k = 0; k < 4; k++)
				read_check({rand_byte(), 8'hFE}, 1'b1);
		end

		for (int i = 0; i < N_MUS; i++)
		begin
			load_byte(CMD_MUSX, rand_byte());
			load_byte(CMD_MUSY, rand_byte());
			load_byte(CMD_MUSBTN, rand_byte());
			read_check(16'hFADF, 1'b1);
			read_check(16'hFBDF, 1'b1);
			read_check(16'hFFDF, 1'b1);
			read_check({rand_byte(), PORT_MUS_LO}, 1'b1);
		end

		for (int i = 0; i < N_KJ; i++)
		begin
			load_byte(CMD_KJ, rand_byte());
			read_check(16'h001F, 1'b1);
			read_check({rand_byte(), PORT_KJ_LO}, 1'b1);
		end

		// keyboard frame cut short after three payload bytes
		tx_buf[0] = CMD_KBD;
		for (int n = 1; n < 4; n++)
			tx_buf[n] = rand_byte();
		send_frame(4);
		sweep_ports();

		// unknown command with a full length payload
		tx_buf[0] = 8'h55;
		for (int n = 1; n < KBD_BYTES + 1; n++)
			tx_buf[n] = rand_byte();
		send_frame(KBD_BYTES + 1);
		sweep_ports();

		for (int i = 0; i < 6; i++)
		begin
			lo = rand_byte() | 8'h01;
			if (lo == PORT_KJ_LO || lo == PORT_MUS_LO)
				lo = lo ^ 8'h20;
			read_check({rand_byte(), lo}, 1'b1);
		end
		read_check(16'hFEFE, 1'b0); // nothing driven without iorq
		read_check(16'h001F, 1'b0);
		read_check(16'hFBDF, 1'b0);

		repeat (4) @(posedge fclk);
		$display("checks %0d, errors %0d", n_checks, err_count);
		if (err_count == 0 && n_checks > 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	// bound from frame count and length plus read time
	initial
	begin
		#(TIMEOUT_NS);
		$display("timeout: tests did not complete within %0d ns", TIMEOUT_NS);
		$display("checks %0d, errors %0d", n_checks, err_count);
		$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== vlog.f ====
zx_periph_pkg.sv
periph_load_if.sv
slave_spi_rx.sv
spi_cmd_ctrl.sv
kbd_mus_regs.sv
zport_read_mux.sv
zkbd_top.sv
tb_clkgen.sv
tb_zkbd.sv

// ==== Bender.yml ====
package:
  name: zkbd

sources:
  - zx_periph_pkg.sv
  - periph_load_if.sv
  - slave_spi_rx.sv
  - spi_cmd_ctrl.sv
  - kbd_mus_regs.sv
  - zport_read_mux.sv
  - zkbd_top.sv
  - target: simulation
    files:
      - tb_clkgen.sv
      - tb_zkbd.sv
